// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

	typedef logic [31:0] addrT;
	typedef logic [31:0] wordT;
	typedef logic [3:0]  byteEnT;
	typedef logic [3:0]  wayMaskT;
	typedef logic [5:0]  lruT;	// pairwise age bits between the four ways
	typedef logic [18:0] tagT;	// address 28:10 in the default geometry

	typedef enum logic [1:0] {cacheArea, noCacheArea, ioArea, otherArea} areaE;
	typedef enum logic [1:0] {opRead, opWrite, opLineFill} opKindE;

	typedef struct packed {
		logic [2:0] rsvdHi;
		logic       cpBit;	// purge, clears itself
		logic [2:0] rsvdLo;
		logic       ceBit;	// cache enable
	} ccrT;

	localparam addrT       ccrAddr      = 32'hFFFFFE92;
	localparam logic [7:0] ccrWriteMask = 8'h11;
	localparam logic [7:0] ccrReadMask  = 8'h01;

	// oldest way according to the age bits
	function automatic wayMaskT victimWay(input lruT lru);
		if (lru[5] && lru[4] && lru[3])
			return 4'b0001;
		else if (!lru[5] && lru[2] && lru[1])
			return 4'b0010;
		else if (!lru[4] && !lru[2] && lru[0])
			return 4'b0100;
		else if (!lru[3] && !lru[1] && !lru[0])
			return 4'b1000;
		return 4'b0001;	// inconsistent orderings fall back to way 0
	endfunction

	function automatic lruT lruTouch(input wayMaskT way, input lruT lru);
		lruT res;
		res = lru;
		if (way[3]) begin
			res[3] = 1'b1;
			res[1] = 1'b1;
			res[0] = 1'b1;
		end else if (way[2]) begin
			res[4] = 1'b1;
			res[2] = 1'b1;
			res[0] = 1'b0;
		end else if (way[1]) begin
			res[5] = 1'b1;
			res[2] = 1'b0;
			res[1] = 1'b0;
		end else begin
			res[5:3] = 3'b000;
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== common/arrayIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface arrayIf import cachePkg::*; ();

	addrT    lookupAddr;
	addrT    wrAddr;
	wordT    wrData;
	byteEnT  wrBe;
	wayMaskT wrWay;
	logic    hitWrite;	// byte merge into the hitting way
	logic    fillWrite;	// full word from a burst beat
	logic    touch;
	logic    purgeAll;
	logic    hit;
	wayMaskT hitWay;
	wayMaskT victim;
	wordT    rdData;

	modport decode (
		output lookupAddr, wrAddr, wrData, wrBe, wrWay,
		output hitWrite, fillWrite, touch, purgeAll,
		input  hit, hitWay, victim
	);

	modport arrays (
		input  lookupAddr, wrAddr, wrData, wrBe, wrWay,
		input  hitWrite, fillWrite, touch, purgeAll,
		output hit, hitWay, victim, rdData
	);

	modport result (input rdData);

endinterface

`default_nettype wire

// ==== common/fillIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fillIf import cachePkg::*; ();

	logic    start;
	addrT    opAddr;
	wordT    opData;
	byteEnT  opBe;
	opKindE  kind;
	wayMaskT fillWay;	// victim latched at the miss
	logic    active;
	wordT    beatData;
	addrT    beatAddr;
	logic    beatValid;
	logic    done;

	modport decode (
		output start, opAddr, opData, opBe, kind, fillWay,
		input  active, beatData, beatAddr, beatValid, done
	);

	modport seq (
		input  start, opAddr, opData, opBe, kind,
		output active, beatData, beatAddr, beatValid, done
	);

	modport result (input start, kind, active, beatData, done);

endinterface

`default_nettype wire

// ==== cache/accessDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module accessDecode import cachePkg::*; (
	input  wire         CLK,
	input  wire         RST_N,
	input  wire addrT   cbusAddr,
	input  wire wordT   cbusDataIn,
	input  wire         cbusWr,
	input  wire byteEnT cbusBe,
	input  wire         cbusReq,
	arrayIf.decode      arr,
	fillIf.decode       fill,
	output ccrT         ccr
);

	areaE area;
	logic ccrSel;
	logic canIssue;
	logic cacheOn;
	logic hitRead;
	logic lineFill;
	logic extRead;
	logic extWrite;
	logic ccrWrite;
	logic pending;	// read already sent out for the held request
	logic served;
	logic fillBusy;

	always_comb begin
		case (cbusAddr[31:29])
			3'b000:  area = cacheArea;
			3'b001:  area = noCacheArea;
			3'b111:  area = ioArea;
			default: area = otherArea;
		endcase
	end

	assign ccrSel = (cbusAddr == ccrAddr);

	// nothing new goes out while the bus is busy or a purge is running
	assign canIssue = cbusReq && !fill.active && !pending && !ccr.cpBit;
	assign cacheOn  = (area == cacheArea) && ccr.ceBit;
	assign hitRead  = canIssue && !cbusWr && cacheOn && arr.hit;
	assign lineFill = canIssue && !cbusWr && cacheOn && !arr.hit;
	assign extRead  = canIssue && !cbusWr && !ccrSel && !cacheOn && (area != otherArea);
	assign extWrite = canIssue && cbusWr && !ccrSel && (area != otherArea);
	assign ccrWrite = canIssue && cbusWr && ccrSel;

	assign fill.start  = extRead || extWrite || lineFill;
	assign fill.opAddr = cbusAddr;
	assign fill.opData = cbusDataIn;
	assign fill.opBe   = cbusBe;

	always_comb begin
		if (lineFill)
			fill.kind = opLineFill;
		else if (extWrite)
			fill.kind = opWrite;
		else
			fill.kind = opRead;
	end

	assign arr.lookupAddr = cbusAddr;
	assign arr.wrAddr     = fillBusy ? fill.beatAddr : cbusAddr;
	assign arr.wrData     = fillBusy ? fill.beatData : cbusDataIn;
	assign arr.wrBe       = cbusBe;
	assign arr.wrWay      = fillBusy ? fill.fillWay : arr.hitWay;
	assign arr.hitWrite   = extWrite && cacheOn && arr.hit;	// write-through also updates the line
	assign arr.fillWrite  = fillBusy && fill.beatValid;
	assign arr.touch      = hitRead;
	assign arr.purgeAll   = ccr.cpBit;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr      <= '0;
			pending  <= 1'b0;
			served   <= 1'b0;
			fillBusy <= 1'b0;
		end else begin
			served <= fill.done;
			if (extRead || lineFill)
				pending <= 1'b1;
			else if (served)
				pending <= 1'b0;	// CPU takes the word in this cycle
			if (lineFill)
				fillBusy <= 1'b1;
			else if (fill.done)
				fillBusy <= 1'b0;
			if (ccrWrite)
				ccr <= ccrT'(cbusDataIn[7:0] & ccrWriteMask);
			else if (ccr.cpBit)
				ccr.cpBit <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (lineFill)
			fill.fillWay <= arr.victim;
	end

endmodule

`default_nettype wire

// ==== cache/wayArrays.sv ====
`timescale 1ns/1ns
`default_nettype none

module wayArrays import cachePkg::*; #(
	parameter int numSets      = 64,
	parameter int wordsPerLine = 4
) (
	input  wire    CLK,
	input  wire    RST_N,
	arrayIf.arrays arr
);

	localparam int offW   = $clog2(wordsPerLine);
	localparam int idxW   = $clog2(numSets);
	localparam int tagLsb = 2 + offW + idxW;
	localparam int depth  = numSets * wordsPerLine;

	logic [idxW-1:0]      rdSet;
	logic [idxW-1:0]      wrSet;
	logic [idxW+offW-1:0] rdWord;
	logic [idxW+offW-1:0] wrWord;
	tagT                  rdTag;
	tagT                  wrTag;
	wire wayMaskT         hitVec;
	wordT                 wayData [4];
	lruT                  lruMem [numSets];

	assign rdSet  = arr.lookupAddr[tagLsb-1 -: idxW];
	assign wrSet  = arr.wrAddr[tagLsb-1 -: idxW];
	assign rdWord = arr.lookupAddr[tagLsb-1:2];
	assign wrWord = arr.wrAddr[tagLsb-1:2];
	assign rdTag  = tagT'(arr.lookupAddr[28:0] >> tagLsb);
	assign wrTag  = tagT'(arr.wrAddr[28:0] >> tagLsb);

	for (genvar w = 0; w < 4; w++) begin : gWay
		tagT             tagMem [numSets];
		logic [numSets-1:0] valid;
		logic [3:0][7:0] dataMem [depth];

		assign hitVec[w]  = valid[rdSet] && (tagMem[rdSet] == rdTag);
		assign wayData[w] = dataMem[rdWord];

		always_ff @(posedge CLK) begin
			if (arr.fillWrite && arr.wrWay[w]) begin
				dataMem[wrWord] <= arr.wrData;
				tagMem[wrSet]   <= wrTag;
			end else if (arr.hitWrite && arr.wrWay[w]) begin
				for (int b = 0; b < 4; b++) begin
					if (arr.wrBe[b])
						dataMem[wrWord][b] <= arr.wrData[8*b +: 8];
				end
			end
		end

		always_ff @(posedge CLK or negedge RST_N) begin
			if (!RST_N)
				valid <= '0;
			else if (arr.purgeAll)
				valid <= '0;
			else if (arr.fillWrite && arr.wrWay[w])
				valid[wrSet] <= 1'b1;
		end
	end

	always_comb begin
		arr.rdData = '0;
		for (int w = 3; w >= 0; w--) begin
			if (hitVec[w])
				arr.rdData = wayData[w];
		end
	end

	assign arr.hitWay = hitVec;
	assign arr.hit    = |hitVec;
	assign arr.victim = victimWay(lruMem[rdSet]);

	// a fill touches on every beat, the same way each time, so the last beat leaves the order
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			lruMem <= '{default: '0};
		else if (arr.purgeAll)
			lruMem <= '{default: '0};
		else if (arr.touch || arr.fillWrite)
			lruMem[wrSet] <= lruTouch(arr.wrWay, lruMem[wrSet]);
	end

endmodule

`default_nettype wire

// ==== cache/extBusSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module extBusSequencer import cachePkg::*; #(
	parameter int wordsPerLine = 4
) (
	input  wire       CLK,
	input  wire       RST_N,
	output addrT      ibusAddr,
	input  wire wordT ibusDataIn,
	output wordT      ibusDataOut,
	output byteEnT    ibusBe,
	output logic      ibusWe,
	output logic      ibusReq,
	output logic      ibusBurst,
	input  wire       ibusWait,
	fillIf.seq        fill
);

	localparam int offW = $clog2(wordsPerLine);

	typedef enum logic [1:0] {idle, single, burst} stateE;

	stateE           state;
	logic [offW-1:0] beatCnt;
	logic            beatOk;
	logic            lastBeat;
	logic            launch;

	assign launch   = (state == idle) && fill.start;
	assign beatOk   = ibusReq && !ibusWait;	// beat taken at this edge
	assign lastBeat = (state == single) || (beatCnt == offW'(wordsPerLine - 1));

	assign fill.active    = (state != idle);
	assign fill.beatValid = beatOk;
	assign fill.beatData  = ibusDataIn;
	assign fill.beatAddr  = ibusAddr;
	assign fill.done      = beatOk && lastBeat;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= idle;
			ibusReq   <= 1'b0;
			ibusWe    <= 1'b0;
			ibusBurst <= 1'b0;
			beatCnt   <= '0;
		end else if (launch) begin
			ibusReq   <= 1'b1;
			ibusWe    <= (fill.kind == opWrite);
			ibusBurst <= (fill.kind == opLineFill);
			beatCnt   <= '0;
			if (fill.kind == opLineFill)
				state <= burst;
			else
				state <= single;
		end else if (beatOk) begin
			if (lastBeat) begin
				state     <= idle;
				ibusReq   <= 1'b0;
				ibusWe    <= 1'b0;
				ibusBurst <= 1'b0;
			end else begin
				beatCnt <= beatCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (launch) begin
			ibusAddr    <= fill.opAddr;
			ibusDataOut <= fill.opData;
			ibusBe      <= fill.opBe;
			if (fill.kind == opLineFill) begin
				// start one word past the request so it arrives last
				ibusAddr[offW+1:2] <= fill.opAddr[offW+1:2] + 1'b1;
				ibusBe             <= '1;
			end
		end else if (state == burst && beatOk) begin
			ibusAddr[offW+1:2] <= ibusAddr[offW+1:2] + 1'b1;	// wraps inside the line
		end
	end

endmodule

`default_nettype wire

// ==== design/readReturn.sv ====
`timescale 1ns/1ns
`default_nettype none

module readReturn import cachePkg::*; (
	input  wire       CLK,
	input  wire       RST_N,
	input  wire addrT cbusAddr,
	input  wire       cbusReq,
	input  wire ccrT  ccr,
	arrayIf.result    arr,
	fillIf.result     fill,
	output wordT      cbusDataOut,
	output logic      cbusBusy
);

	wordT heldWord;
	logic returned;	// held word is valid for this cycle only
	logic readPend;
	logic readStart;

	assign readStart = fill.start && (fill.kind != opWrite);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			returned <= 1'b0;
			readPend <= 1'b0;
		end else begin
			returned <= fill.done && readPend;
			if (readStart)
				readPend <= 1'b1;
			else if (fill.done)
				readPend <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (fill.done && readPend)
			heldWord <= fill.beatData;
	end

	assign cbusDataOut = (cbusAddr == ccrAddr) ? {4{ccr & ccrReadMask}} :
	                     returned              ? heldWord :
	                                             arr.rdData;

	// purge cycle also holds the CPU so no stale hit slips through
	assign cbusBusy = cbusReq && !returned && (fill.active || readStart || ccr.cpBit);

endmodule

`default_nettype wire

// ==== design/cacheTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheTop import cachePkg::*; #(
	parameter int numSets      = 64,
	parameter int wordsPerLine = 4
) (
	input  wire         CLK,
	input  wire         RST_N,

	input  wire addrT   cbusAddr,
	input  wire wordT   cbusDataIn,
	output wordT        cbusDataOut,
	input  wire         cbusWr,
	input  wire byteEnT cbusBe,
	input  wire         cbusReq,
	output logic        cbusBusy,

	output addrT        ibusAddr,
	input  wire wordT   ibusDataIn,
	output wordT        ibusDataOut,
	output byteEnT      ibusBe,
	output logic        ibusWe,
	output logic        ibusReq,
	output logic        ibusBurst,
	input  wire         ibusWait
);

	arrayIf arrBus ();
	fillIf  fillBus ();
	ccrT    ccr;

	accessDecode uDecode (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cbusAddr   (cbusAddr),
		.cbusDataIn (cbusDataIn),
		.cbusWr     (cbusWr),
		.cbusBe     (cbusBe),
		.cbusReq    (cbusReq),
		.arr        (arrBus.decode),
		.fill       (fillBus.decode),
		.ccr        (ccr)
	);

	wayArrays #(
		.numSets      (numSets),
		.wordsPerLine (wordsPerLine)
	) uArrays (
		.CLK   (CLK),
		.RST_N (RST_N),
		.arr   (arrBus.arrays)
	);

	extBusSequencer #(
		.wordsPerLine (wordsPerLine)
	) uSeq (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.ibusAddr    (ibusAddr),
		.ibusDataIn  (ibusDataIn),
		.ibusDataOut (ibusDataOut),
		.ibusBe      (ibusBe),
		.ibusWe      (ibusWe),
		.ibusReq     (ibusReq),
		.ibusBurst   (ibusBurst),
		.ibusWait    (ibusWait),
		.fill        (fillBus.seq)
	);

	readReturn uReturn (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.cbusAddr    (cbusAddr),
		.cbusReq     (cbusReq),
		.ccr         (ccr),
		.arr         (arrBus.result),
		.fill        (fillBus.result),
		.cbusDataOut (cbusDataOut),
		.cbusBusy    (cbusBusy)
	);

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int periodNs = 4
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever #(periodNs / 2) CLK = ~CLK;
	end

endmodule

`default_nettype wire

// ==== bench/tbCache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbCache import cachePkg::*; ();

	localparam int clkPeriod = 4;
	localparam int maxTests  = 40;
	localparam int cols      = 6;	// op, addr, data, be, expected read, expected beats

	typedef struct packed {
		addrT   addr;
		wordT   data;
		byteEnT be;
		logic   we;
		logic   burst;
	} beatT;

	logic   CLK;
	logic   RST_N;
	addrT   cbusAddr;
	wordT   cbusDataIn;
	wordT   cbusDataOut;
	logic   cbusWr;
	byteEnT cbusBe;
	logic   cbusReq;
	logic   cbusBusy;
	addrT   ibusAddr;
	wordT   ibusDataIn;
	wordT   ibusDataOut;
	byteEnT ibusBe;
	logic   ibusWe;
	logic   ibusReq;
	logic   ibusBurst;
	logic   ibusWait;

	logic [31:0] golden [maxTests*cols];
	wordT        memWords [addrT];
	beatT        beatLog [$];	// external beats of the running test
	int          numTests;
	int          checkCount;
	int          errorCount;
	int          watchdogNs;

	clockGen #(.periodNs(clkPeriod)) uClock (.CLK(CLK));

	cacheTop u_cacheTop (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.cbusAddr    (cbusAddr),
		.cbusDataIn  (cbusDataIn),
		.cbusDataOut (cbusDataOut),
		.cbusWr      (cbusWr),
		.cbusBe      (cbusBe),
		.cbusReq     (cbusReq),
		.cbusBusy    (cbusBusy),
		.ibusAddr    (ibusAddr),
		.ibusDataIn  (ibusDataIn),
		.ibusDataOut (ibusDataOut),
		.ibusBe      (ibusBe),
		.ibusWe      (ibusWe),
		.ibusReq     (ibusReq),
		.ibusBurst   (ibusBurst),
		.ibusWait    (ibusWait)
	);

	// unwritten memory reads back as its word address xor 5A5A5A5A
	function automatic wordT memRead(input addrT a);
		addrT key;
		key = {a[31:2], 2'b00};
		if (memWords.exists(key))
			return memWords[key];
		return key ^ 32'h5A5A5A5A;
	endfunction

	function automatic void memWrite(input addrT a, input wordT d, input byteEnT be);
		wordT merged;
		merged = memRead(a);
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				merged[8*b +: 8] = d[8*b +: 8];
		end
		memWords[{a[31:2], 2'b00}] = merged;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic runTest(input int t);
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] be;
		logic [31:0] expData;
		logic [31:0] expBeats;
		logic        expBusy;
		wordT        gotData;
		beatT        rec;
		int          errsBefore;
		op         = golden[t*cols];
		addr       = golden[t*cols+1];
		data       = golden[t*cols+2];
		be         = golden[t*cols+3];
		expData    = golden[t*cols+4];
		expBeats   = golden[t*cols+5];
		expBusy    = !op[0] && (expBeats != 0);	// only external reads stall the CPU
		errsBefore = errorCount;
		beatLog.delete();
		@(posedge CLK);
		cbusReq    <= 1'b1;
		cbusWr     <= op[0];
		cbusAddr   <= addr;
		cbusDataIn <= data;
		cbusBe     <= be[3:0];
		@(negedge CLK);
		checkValue("cbusBusy", cbusBusy, expBusy);
		while (cbusBusy)
			@(negedge CLK);
		gotData = cbusDataOut;
		@(posedge CLK);	// request completes at this edge
		cbusReq <= 1'b0;
		cbusWr  <= 1'b0;
		@(negedge CLK);
		while (ibusReq)	// let a write-through finish on the bus
			@(negedge CLK);
		if (!op[0])
			checkValue("cbusDataOut", gotData, expData);
		checkValue("beat count", beatLog.size(), expBeats);
		if (beatLog.size() == expBeats) begin
			for (int i = 0; i < beatLog.size(); i++) begin
				rec = beatLog[i];
				if (expBeats == 4) begin
					// wrapping order, requested word comes last
					checkValue("ibusBurst", rec.burst, 1);
					checkValue("ibusWe", rec.we, 0);
					checkValue("ibusAddr", rec.addr, {addr[31:4], 2'(addr[3:2] + i + 1), 2'b00});
				end else begin
					checkValue("ibusBurst", rec.burst, 0);
					checkValue("ibusWe", rec.we, op[0]);
					checkValue("ibusAddr", rec.addr, addr);
					checkValue("ibusBe", rec.be, be[3:0]);
					if (op[0])
						checkValue("ibusDataOut", rec.data, data);
				end
			end
		end
		$display("test %0d: %s %h, %0d beats, %s", t, op[0] ? "write" : "read", addr,
			beatLog.size(), (errorCount == errsBefore) ? "ok" : "mismatch");
	endtask

	// external memory, one look cycle per beat and then 0 to 3 random wait cycles
	initial begin
		int unsigned seed;
		int unsigned stallLeft;
		logic        armed;
		logic        reqS;
		logic        weS;
		logic        burstS;
		addrT        addrS;
		wordT        doutS;
		byteEnT      beS;
		seed = 32'h3ae6;
		void'($urandom(seed));
		stallLeft  = 0;
		armed      = 1'b0;
		ibusWait   = 1'b1;
		ibusDataIn = '0;
		forever begin
			@(negedge CLK);
			reqS   = ibusReq;
			weS    = ibusWe;
			burstS = ibusBurst;
			addrS  = ibusAddr;
			doutS  = ibusDataOut;
			beS    = ibusBe;
			@(posedge CLK);
			if (reqS && !ibusWait) begin	// beat accepted at this edge
				beatLog.push_back('{addrS, doutS, beS, weS, burstS});
				if (weS)
					memWrite(addrS, doutS, beS);
				ibusWait <= 1'b1;
				armed = 1'b0;
			end else if (reqS) begin
				if (!armed) begin
					stallLeft = $urandom_range(3, 0);
					armed     = 1'b1;
				end
				if (stallLeft == 0) begin
					ibusWait   <= 1'b0;
					ibusDataIn <= memRead(addrS);
				end else begin
					stallLeft--;
				end
			end
		end
	end

	initial begin
		RST_N      = 1'b0;
		cbusReq    = 1'b0;
		cbusWr     = 1'b0;
		cbusAddr   = '0;
		cbusDataIn = '0;
		cbusBe     = '0;
		checkCount = 0;
		errorCount = 0;
		for (int i = 0; i < maxTests; i++)
			golden[i*cols] = 32'hFFFFFFFF;	// end marker where the file stops
		$readmemh("bench/cacheGolden.txt", golden);
		numTests = 0;
		while (numTests < maxTests && golden[numTests*cols] != 32'hFFFFFFFF)
			numTests++;
		if (numTests == 0) begin
			errorCount++;
			$display("the golden file bench/cacheGolden.txt holds no tests");
		end
		watchdogNs = (numTests * 40 + 8) * clkPeriod;
		fork
			begin
				#(watchdogNs);
				$display("timeout after %0d ns, the DUT never finished the access", watchdogNs);
				$display("Testbench failed");
				$finish;
			end
		join_none
		repeat (4) @(posedge CLK);
		RST_N <= 1'b1;
		for (int t = 0; t < numTests; t++)
			runTest(t);
		$display("%0d tests, %0d checks, %0d errors", numTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
common/cachePkg.sv
common/arrayIf.sv
common/fillIf.sv
cache/accessDecode.sv
cache/wayArrays.sv
cache/extBusSequencer.sv
design/readReturn.sv
design/cacheTop.sv
bench/clockGen.sv
bench/tbCache.sv

// ==== Bender.yml ====
package:
  name: cache_ctrl

sources:
  - common/cachePkg.sv
  - common/arrayIf.sv
  - common/fillIf.sv
  - cache/accessDecode.sv
  - cache/wayArrays.sv
  - cache/extBusSequencer.sv
  - design/readReturn.sv
  - design/cacheTop.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/tbCache.sv

// ==== bench/cacheGolden.txt ====
// columns: op (0 read, 1 write), address, write data, byte enables, expected read, beats
// all hex, beats counts accepted external bus beats of the access
1 FFFFFE92 000000FF F 00000000 0
0 FFFFFE92 00000000 F 01010101 0
1 FFFFFE92 00000000 F 00000000 0
0 FFFFFE92 00000000 F 00000000 0
0 00000124 00000000 F 5A5A5B7E 1
0 20000040 00000000 F 7A5A5A1A 1
1 FFFFFE92 00000001 F 00000000 0
0 00000128 00000000 F 5A5A5B72 4
0 00000120 00000000 F 5A5A5B7A 0
0 0000012C 00000000 F 5A5A5B76 0
1 00000124 11223344 5 00000000 1
0 00000124 00000000 F 5A225B44 0
0 E0000010 00000000 F BA5A5A4A 1
0 00000050 00000000 F 5A5A5A0A 4
0 00000450 00000000 F 5A5A5E0A 4
0 00000050 00000000 F 5A5A5A0A 0
0 00000850 00000000 F 5A5A520A 4
0 00000050 00000000 F 5A5A5A0A 0
0 00000C50 00000000 F 5A5A560A 4
0 00000050 00000000 F 5A5A5A0A 0
0 00001050 00000000 F 5A5A4A0A 4
0 00000050 00000000 F 5A5A5A0A 0
0 00000450 00000000 F 5A5A5E0A 4
0 00000C50 00000000 F 5A5A560A 0
0 00001050 00000000 F 5A5A4A0A 0
1 FFFFFE92 00000011 F 00000000 0
0 FFFFFE92 00000000 F 01010101 0
0 00000124 00000000 F 5A225B44 4
